//--- chan_acc_defines.svh
`ifndef CHAN_ACC_DEFINES_SVH
`define CHAN_ACC_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Data and image geometry
//////////////////////////////////////////////////////////////////////

// Pixel and partial-sum width
`define CA_DATA_WIDTH 16

// Pixels per row and per plane
`define CA_IMAGE_WIDTH 4
`define CA_IMAGE_SIZE 16

// Input channels summed into one output plane
`define CA_CHANNEL_NUM 3

// Idle cycles after each burst so the adder pipeline drains
`define CA_PLANE_GAP (`CA_IMAGE_WIDTH + 1)

//////////////////////////////////////////////////////////////////////
// Derived widths
//////////////////////////////////////////////////////////////////////

`define CA_ADDR_WIDTH $clog2(`CA_IMAGE_SIZE)
`define CA_COUNT_WIDTH $clog2(`CA_IMAGE_SIZE + 1)
`define CA_CHAN_WIDTH $clog2(`CA_CHANNEL_NUM + 1)

`endif

//--- chan_acc_pkg.sv
`default_nettype none
`include "chan_acc_defines.svh"

package chan_acc_pkg;

  //////////////////////////////////////////////////////////////////////
  // Opcodes and states
  //////////////////////////////////////////////////////////////////////

  // Load starts a fresh sum, accumulate adds to the stored one
  typedef enum logic {
    OP_LOAD,
    OP_ACCUM
  } acc_op_e;

  // Plane sequencer FSM
  typedef enum logic [1:0] {
    SEQ_WAIT,
    SEQ_BURST,
    SEQ_GAP
  } seq_state_e;

  //////////////////////////////////////////////////////////////////////
  // Stage payloads
  //////////////////////////////////////////////////////////////////////

  // Decode to execute
  typedef struct packed {
    acc_op_e                   op;
    logic                      last;
    logic [`CA_ADDR_WIDTH-1:0] addr;
    logic [`CA_DATA_WIDTH-1:0] pxl;
  } acc_cmd_t;

  // Execute to result
  typedef struct packed {
    logic                      last;
    logic [`CA_ADDR_WIDTH-1:0] addr;
    logic [`CA_DATA_WIDTH-1:0] sum;
  } acc_res_t;

endpackage

`default_nettype wire

//--- pixel_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "chan_acc_defines.svh"

module pixel_fifo (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       wr_en,
  input  logic [`CA_DATA_WIDTH-1:0]  din,
  input  logic                       rd_en,
  output logic [`CA_DATA_WIDTH-1:0]  dout,
  output logic [`CA_COUNT_WIDTH-1:0] fifo_count
);

  localparam int DEPTH = `CA_IMAGE_SIZE;

  logic [`CA_DATA_WIDTH-1:0] mem [DEPTH];
  logic [`CA_ADDR_WIDTH-1:0] wr_ptr;
  logic [`CA_ADDR_WIDTH-1:0] rd_ptr;
  logic                      full;
  logic                      empty;

  assign full  = (fifo_count == DEPTH);
  assign empty = (fifo_count == 0);

  // Storage with registered read port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
    if (rd_en) begin
      dout <= mem[rd_ptr];
    end
  end

  // Pointers wrap at one plane
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fifo_count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   fifo_count <= fifo_count + 1'b1;
        2'b01:   fifo_count <= fifo_count - 1'b1;
        default: fifo_count <= fifo_count;
      endcase
    end
  end

  // Writer may only top up a full buffer while it is being drained
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    (wr_en && full) |-> rd_en)
    else $error("pixel_fifo: write into a full buffer");

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> !empty)
    else $error("pixel_fifo: read from an empty buffer");

endmodule

`default_nettype wire

//--- plane_sequencer.sv
`timescale 1ns/1ns
`default_nettype none
`include "chan_acc_defines.svh"

module plane_sequencer
  import chan_acc_pkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic [`CA_COUNT_WIDTH-1:0] fifo_count,
  input  logic [`CA_DATA_WIDTH-1:0]  fifo_dout,
  output logic                       rd_en,
  output logic [`CA_ADDR_WIDTH-1:0]  psum_rd_addr,
  output acc_cmd_t                   cmd,
  output logic                       cmd_valid
);

  localparam int GAP_WIDTH = $clog2(`CA_PLANE_GAP + 1);

  seq_state_e                state;
  logic [`CA_ADDR_WIDTH-1:0] pix_cnt;
  logic [GAP_WIDTH-1:0]      gap_cnt;
  logic [`CA_CHAN_WIDTH-1:0] chan_cnt;

  // Tag of the pixel being read, aligned with fifo_dout
  acc_op_e                   op_q;
  logic                      last_q;
  logic [`CA_ADDR_WIDTH-1:0] addr_q;

  ////////////////////////////////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= SEQ_WAIT;
      rd_en    <= 1'b0;
      pix_cnt  <= '0;
      gap_cnt  <= '0;
      chan_cnt <= '0;
    end else begin
      case (state)
        SEQ_WAIT: begin
          if (fifo_count >= `CA_IMAGE_SIZE) begin
            state   <= SEQ_BURST;
            rd_en   <= 1'b1;
            pix_cnt <= '0;
          end
        end
        SEQ_BURST: begin
          if (int'(pix_cnt) == `CA_IMAGE_SIZE - 1) begin
            state   <= SEQ_GAP;
            rd_en   <= 1'b0;
            gap_cnt <= '0;
            // Next plane belongs to the next channel
            if (int'(chan_cnt) == `CA_CHANNEL_NUM - 1) begin
              chan_cnt <= '0;
            end else begin
              chan_cnt <= chan_cnt + 1'b1;
            end
          end else begin
            pix_cnt <= pix_cnt + 1'b1;
          end
        end
        SEQ_GAP: begin
          if (int'(gap_cnt) == `CA_PLANE_GAP - 1) begin
            state <= SEQ_WAIT;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: begin
          state <= SEQ_WAIT;
          rd_en <= 1'b0;
        end
      endcase
    end
  end

  // Partial sum is fetched in the read cycle
  assign psum_rd_addr = pix_cnt;

  ////////////////////////////////////////////////////////////////////
  // Command tagging
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= rd_en;
    end
  end

  always_ff @(posedge clk) begin
    op_q   <= (chan_cnt == '0) ? OP_LOAD : OP_ACCUM;
    last_q <= (int'(chan_cnt) == `CA_CHANNEL_NUM - 1);
    addr_q <= pix_cnt;
  end

  assign cmd = '{op: op_q, last: last_q, addr: addr_q, pxl: fifo_dout};

  a_no_read_in_wait: assert property (@(posedge clk) disable iff (reset)
    rd_en |-> (state != SEQ_WAIT))
    else $error("plane_sequencer: rd_en high while waiting for a plane");

  // A burst is one whole plane with no holes
  a_full_burst: assert property (@(posedge clk) disable iff (reset)
    $rose(rd_en) |-> rd_en [*`CA_IMAGE_SIZE] ##1 !rd_en)
    else $error("plane_sequencer: burst length differs from plane size");

endmodule

`default_nettype wire

//--- psum_adder.sv
`timescale 1ns/1ns
`default_nettype none
`include "chan_acc_defines.svh"

module psum_adder
  import chan_acc_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  acc_cmd_t                  cmd,
  input  logic                      cmd_valid,
  input  logic [`CA_DATA_WIDTH-1:0] psum_rd_data,
  output acc_res_t                  res,
  output logic                      res_valid
);

  // Stage one holds both operands
  logic                      s1_valid;
  logic                      s1_last;
  logic [`CA_ADDR_WIDTH-1:0] s1_addr;
  logic [`CA_DATA_WIDTH-1:0] s1_a;
  logic [`CA_DATA_WIDTH-1:0] s1_b;

  ////////////////////////////////////////////////////////////////////
  // Valid pipeline
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      res_valid <= 1'b0;
    end else begin
      s1_valid  <= cmd_valid;
      res_valid <= s1_valid;
    end
  end

  // Stage one, first channel ignores the stored sum
  always_ff @(posedge clk) begin
    s1_last <= cmd.last;
    s1_addr <= cmd.addr;
    s1_a    <= cmd.pxl;
    s1_b    <= (cmd.op == OP_LOAD) ? '0 : psum_rd_data;
  end

  // Stage two, wraps modulo 2**DATA_WIDTH
  always_ff @(posedge clk) begin
    res.last <= s1_last;
    res.addr <= s1_addr;
    res.sum  <= s1_a + s1_b;
  end

endmodule

`default_nettype wire

//--- psum_store.sv
`timescale 1ns/1ns
`default_nettype none
`include "chan_acc_defines.svh"

module psum_store
  import chan_acc_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`CA_ADDR_WIDTH-1:0] psum_rd_addr,
  output logic [`CA_DATA_WIDTH-1:0] psum_rd_data,
  input  acc_res_t                  res,
  input  logic                      res_valid,
  output logic [`CA_DATA_WIDTH-1:0] pxl_out,
  output logic                      valid_out
);

  // One partial sum per pixel position
  logic [`CA_DATA_WIDTH-1:0] psum_mem [`CA_IMAGE_SIZE];

  ////////////////////////////////////////////////////////////////////
  // Partial-sum plane
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (res_valid) begin
      psum_mem[res.addr] <= res.sum;
    end
  end

  // Registered read, lines up with cmd in the adder
  always_ff @(posedge clk) begin
    psum_rd_data <= psum_mem[psum_rd_addr];
  end

  ////////////////////////////////////////////////////////////////////
  // Final sums
  ////////////////////////////////////////////////////////////////////

  // Only last-channel results leave the block
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_out <= 1'b0;
      pxl_out   <= '0;
    end else if (res_valid && res.last) begin
      valid_out <= 1'b1;
      pxl_out   <= res.sum;
    end else begin
      valid_out <= 1'b0;
      pxl_out   <= '0;
    end
  end

  a_out_follows_res: assert property (@(posedge clk) disable iff (reset)
    valid_out |-> $past(res_valid && res.last))
    else $error("psum_store: valid_out without a last-channel result");

endmodule

`default_nettype wire

//--- conv_channel_accumulator.sv
`timescale 1ns/1ns
`default_nettype none
`include "chan_acc_defines.svh"

module conv_channel_accumulator
  import chan_acc_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      valid_in,
  input  logic [`CA_DATA_WIDTH-1:0] pxl_in,
  output logic [`CA_DATA_WIDTH-1:0] pxl_out,
  output logic                      valid_out
);

  // Input buffer to decode
  logic [`CA_DATA_WIDTH-1:0]  fifo_dout;
  logic [`CA_COUNT_WIDTH-1:0] fifo_count;
  logic                       rd_en;

  // Decode to execute and store
  logic [`CA_ADDR_WIDTH-1:0]  psum_rd_addr;
  acc_cmd_t                   cmd;
  logic                       cmd_valid;

  // Execute to store and back
  logic [`CA_DATA_WIDTH-1:0]  psum_rd_data;
  acc_res_t                   res;
  logic                       res_valid;

  pixel_fifo u_pixel_fifo (
    .clk        (clk),
    .reset      (reset),
    .wr_en      (valid_in),
    .din        (pxl_in),
    .rd_en      (rd_en),
    .dout       (fifo_dout),
    .fifo_count (fifo_count)
  );

  plane_sequencer u_plane_sequencer (
    .clk          (clk),
    .reset        (reset),
    .fifo_count   (fifo_count),
    .fifo_dout    (fifo_dout),
    .rd_en        (rd_en),
    .psum_rd_addr (psum_rd_addr),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid)
  );

  psum_adder u_psum_adder (
    .clk          (clk),
    .reset        (reset),
    .cmd          (cmd),
    .cmd_valid    (cmd_valid),
    .psum_rd_data (psum_rd_data),
    .res          (res),
    .res_valid    (res_valid)
  );

  psum_store u_psum_store (
    .clk          (clk),
    .reset        (reset),
    .psum_rd_addr (psum_rd_addr),
    .psum_rd_data (psum_rd_data),
    .res          (res),
    .res_valid    (res_valid),
    .pxl_out      (pxl_out),
    .valid_out    (valid_out)
  );

endmodule

`default_nettype wire

//--- tb_conv_channel_accumulator.sv
`timescale 1ns/1ns
`default_nettype none
`include "chan_acc_defines.svh"

module tb_conv_channel_accumulator;

  localparam int NUM_IMAGES = 4;
  localparam int NUM_CHAN   = `CA_CHANNEL_NUM;
  localparam int PLANE      = `CA_IMAGE_SIZE;
  localparam int MAX_IDLE   = 8;
  // Sequencer round trip: full-plane check, burst, drain gap
  localparam int SEQ_PERIOD = PLANE + `CA_PLANE_GAP + 1;
  localparam int TIMEOUT_CYCLES =
    NUM_IMAGES * NUM_CHAN * (PLANE + `CA_PLANE_GAP + 40) + 200;

  logic                      clk = 1'b0;
  logic                      reset;
  logic                      valid_in;
  logic [`CA_DATA_WIDTH-1:0] pxl_in;
  logic [`CA_DATA_WIDTH-1:0] pxl_out;
  logic                      valid_out;

  logic [31:0]               lfsr_state;
  logic [`CA_DATA_WIDTH-1:0] stim [NUM_IMAGES][NUM_CHAN][PLANE];
  logic [`CA_DATA_WIDTH-1:0] exp_sum [NUM_IMAGES][PLANE];
  logic [`CA_DATA_WIDTH-1:0] exp_q [$];
  logic [`CA_DATA_WIDTH-1:0] exp_head;
  int                        exp_left;
  int                        out_idx;
  int                        out_img;
  int                        out_total;
  logic                      out_allowed;
  int                        mismatch_count;
  int                        error_count;
  int                        cycle;

  conv_channel_accumulator conv_channel_accumulator_i (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .pxl_in    (pxl_in),
    .pxl_out   (pxl_out),
    .valid_out (valid_out)
  );

  always #4 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // Random bits and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hA300_0000;
    end else begin
      return s >> 1;
    end
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [`CA_DATA_WIDTH-1:0] take_bits(input int n);
    logic [`CA_DATA_WIDTH-1:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits       = {bits[`CA_DATA_WIDTH-2:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return bits;
  endfunction

  // Pixels for every plane, with per-pixel sums queued in raster order
  function automatic void build_stimulus();
    logic [`CA_DATA_WIDTH-1:0] value;
    for (int img = 0; img < NUM_IMAGES; img++) begin
      for (int p = 0; p < PLANE; p++) begin
        exp_sum[img][p] = '0;
      end
      for (int ch = 0; ch < NUM_CHAN; ch++) begin
        for (int p = 0; p < PLANE; p++) begin
          value = take_bits(`CA_DATA_WIDTH);
          // About one pixel in four near full scale, so sums wrap
          if (take_bits(2) == '0) begin
            value[`CA_DATA_WIDTH-1 -: 8] = 8'hFF;
          end
          stim[img][ch][p] = value;
          exp_sum[img][p]  = exp_sum[img][p] + value;
        end
      end
      for (int p = 0; p < PLANE; p++) begin
        exp_q.push_back(exp_sum[img][p]);
      end
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Output tracking
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      out_idx   <= 0;
      out_img   <= 0;
      out_total <= 0;
    end else if (valid_out) begin
      if (exp_q.size() > 0) begin
        void'(exp_q.pop_front());
      end
      exp_left  <= exp_q.size();
      exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
      out_total <= out_total + 1;
      if (out_idx == PLANE - 1) begin
        out_idx <= 0;
        out_img <= out_img + 1;
      end else begin
        out_idx <= out_idx + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d outputs still expected", cycle, exp_left);
      $display("Outputs %0d, mismatches %0d, other errors %0d",
               out_total, mismatch_count, error_count);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  a_quiet_before_last: assert property (@(posedge clk) disable iff (reset)
    !out_allowed |-> !valid_out)
    else begin
      error_count++;
      $display("valid_out went high before any last-channel plane was sent");
    end

  a_zero_when_idle: assert property (@(posedge clk) disable iff (reset)
    !valid_out |-> (pxl_out == '0))
    else begin
      mismatch_count++;
      $display("MISMATCH pxl_out: got %h expected %h while valid_out low",
               $sampled(pxl_out), {`CA_DATA_WIDTH{1'b0}});
    end

  a_output_expected: assert property (@(posedge clk) disable iff (reset)
    valid_out |-> (exp_left > 0))
    else begin
      error_count++;
      $display("valid_out pulse with no expected output left");
    end

  a_sum_value: assert property (@(posedge clk) disable iff (reset)
    valid_out |-> (pxl_out == exp_head))
    else begin
      mismatch_count++;
      $display("MISMATCH pxl_out: got %h expected %h (image %0d pixel %0d)",
               $sampled(pxl_out), $sampled(exp_head), $sampled(out_img),
               $sampled(out_idx));
    end

  // A finished plane leaves as one unbroken run of 16
  a_run_contiguous: assert property (@(posedge clk) disable iff (reset)
    (valid_out && out_idx != PLANE - 1) |=> valid_out)
    else begin
      error_count++;
      $display("Output run of image %0d broke off before pixel %0d",
               out_img, out_idx);
    end

  a_run_length: assert property (@(posedge clk) disable iff (reset)
    (valid_out && out_idx == PLANE - 1) |=> !valid_out)
    else begin
      error_count++;
      $display("Output run longer than one plane at image %0d", out_img);
    end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin : stimulus
    int now;
    int next_ok;
    int seq_free;
    int burst_start;
    int idle_left;
    reset          = 1'b1;
    valid_in       = 1'b0;
    pxl_in         = '0;
    out_allowed    = 1'b0;
    mismatch_count = 0;
    error_count    = 0;
    cycle          = 0;
    lfsr_state     = 32'd76495;
    build_stimulus();
    exp_head = exp_q[0];
    exp_left = exp_q.size();

    repeat (3) @(posedge clk);
    reset    <= 1'b0;
    now      = 0;
    next_ok  = 0;
    seq_free = 0;

    for (int img = 0; img < NUM_IMAGES; img++) begin
      for (int ch = 0; ch < NUM_CHAN; ch++) begin
        // Hold off until the previous plane's burst has begun
        while (now + 1 < next_ok) begin
          valid_in <= 1'b0;
          @(posedge clk);
          now++;
        end
        if (ch == NUM_CHAN - 1) begin
          out_allowed <= 1'b1;
        end
        idle_left = MAX_IDLE;
        for (int p = 0; p < PLANE; p++) begin
          while (idle_left > 0 && take_bits(2) == 'd3) begin
            valid_in <= 1'b0;
            @(posedge clk);
            now++;
            idle_left--;
          end
          valid_in <= 1'b1;
          pxl_in   <= stim[img][ch][p];
          @(posedge clk);
          now++;
        end
        // Burst starts once the plane is complete and the FSM is back in wait
        burst_start = (now + 1 > seq_free) ? now + 1 : seq_free;
        seq_free    = burst_start + SEQ_PERIOD;
        next_ok     = burst_start + 2;
      end
    end
    valid_in <= 1'b0;
    pxl_in   <= '0;

    while (exp_left > 0) begin
      @(posedge clk);
    end
    // Room for any stray pulse after the last run
    repeat (2 * `CA_PLANE_GAP) @(posedge clk);

    a_all_consumed: assert (out_total == NUM_IMAGES * PLANE)
      else begin
        error_count++;
        $display("Run ended with %0d outputs instead of %0d",
                 out_total, NUM_IMAGES * PLANE);
      end

    $display("Outputs %0d, mismatches %0d, other errors %0d",
             out_total, mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
chan_acc_pkg.sv
pixel_fifo.sv
plane_sequencer.sv
psum_adder.sv
psum_store.sv
conv_channel_accumulator.sv
tb_conv_channel_accumulator.sv
